// ==== include/bus_settings.svh ====
// Bus settings for the external Wishbone side.
// Widths, port count, fixed cycle-type codes and the BE-32 lane swap switch.

`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Widths.
// ---------------------------------------------------------------------------

`define BUS_ADDR_W      32
`define BUS_DATA_W      32
`define BUS_SEL_W       4

// Port 0 is code, port 1 is data.
`define BUS_NUM_PORTS   2

// ---------------------------------------------------------------------------
// Wishbone cycle codes.
// ---------------------------------------------------------------------------

`define BUS_CTI_EOB     3'b111
`define BUS_BTE_LINEAR  2'b00

// Swap byte lanes on the data port.
`define BUS_BE32_ENABLE 1'b1

`endif

// ==== logic/bus_types_pkg.sv ====
// Bus types package.
// Word, select and bundle types for the master ports and the Wishbone bus.

`default_nettype none

`include "bus_settings.svh"

package bus_types_pkg;

        typedef logic [`BUS_ADDR_W-1:0] addr_t;
        typedef logic [`BUS_DATA_W-1:0] data_t;
        typedef logic [`BUS_SEL_W-1:0]  sel_t;
        typedef logic [2:0]             cti_t;
        typedef logic [1:0]             bte_t;

        // One request from outside, strobed for a single cycle.
        typedef struct packed {
                logic  stb;
                logic  we;
                addr_t adr;
                data_t dat;
                sel_t  sel;
        } port_req_t;

        // One response. Ack and err are single-cycle pulses.
        typedef struct packed {
                logic  ack;
                logic  err;
                data_t dat;
        } port_rsp_t;

        // Port to merger. Data and selects already lane swapped.
        typedef struct packed {
                logic  pend;
                logic  we;
                addr_t adr;
                data_t dat;
                sel_t  sel;
        } wb_req_t;

        // ------------------------------------------------------------------------
        // External bus.
        // ------------------------------------------------------------------------

        typedef struct packed {
                logic  cyc;
                logic  stb;
                logic  we;
                addr_t adr;
                data_t dat;
                sel_t  sel;
                cti_t  cti;
                bte_t  bte;
        } wb_out_t;

        typedef struct packed {
                logic  ack;
                logic  err;
                data_t dat;
        } wb_in_t;

endpackage

`default_nettype wire

// ==== logic/arb_pkg.sv ====
// Arbitration package.
// Merger state encoding and the port index type.

`default_nettype none

`include "bus_settings.svh"

package arb_pkg;

        // Wide enough to name every port.
        typedef logic [$clog2(`BUS_NUM_PORTS)-1:0] port_id_t;

        // ------------------------------------------------------------------------
        // Merger FSM.
        // ------------------------------------------------------------------------

        typedef enum logic [1:0] {
                IDLE  = 2'd0,
                GRANT = 2'd1,
                DONE  = 2'd2
        } arb_state_e;

endpackage

`default_nettype wire

// ==== logic/bus_port.sv ====
// Single-word master port.
// Latches one request, holds it pending for the merger, and returns
// the response. Optional BE-32 byte-lane swap on data and selects.

`timescale 1ns/10ps
`default_nettype none

`include "bus_settings.svh"

module bus_port
        import bus_types_pkg::*;
#(
        parameter bit SWAP_LANES = 1'b0
)
(
        input  logic      i_clk,
        input  logic      i_arst_n,

        input  port_req_t i_req,

        input  logic      i_done,
        input  logic      i_err,
        input  data_t     i_rdata,

        output wb_req_t   o_wbreq,
        output port_rsp_t o_rsp,
        output logic      o_busy
);

// ---------------------------------------------------------------------------
// Lane swap helpers.
// ---------------------------------------------------------------------------

function automatic data_t swap_bytes(input data_t d);
        data_t r;
        for (int b = 0; b < `BUS_SEL_W; b++)
        begin
                r[8*b +: 8] = d[8*(`BUS_SEL_W-1-b) +: 8];
        end
        return r;
endfunction

function automatic sel_t swap_sel(input sel_t s);
        sel_t r;
        for (int b = 0; b < `BUS_SEL_W; b++)
        begin
                r[b] = s[`BUS_SEL_W-1-b];
        end
        return r;
endfunction

logic  pend_q;
logic  we_q;
addr_t adr_q;
data_t dat_q;
sel_t  sel_q;

logic  ack_q;
logic  err_q;
data_t rdat_q;

data_t wdat;
sel_t  wsel;
data_t rdat;
logic  take;

// New request accepted only while idle.
assign take = i_req.stb & ~pend_q;

always_comb
begin
        if (SWAP_LANES)
        begin
                wdat = swap_bytes(i_req.dat);
                wsel = swap_sel(i_req.sel);
                rdat = swap_bytes(i_rdata);
        end
        else
        begin
                wdat = i_req.dat;
                wsel = i_req.sel;
                rdat = i_rdata;
        end
end

// ---------------------------------------------------------------------------
// Request side.
// ---------------------------------------------------------------------------

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                pend_q <= 1'b0;
        end
        else if (take)
        begin
                pend_q <= 1'b1;
        end
        else if (i_done)
        begin
                pend_q <= 1'b0;
        end
end

// Payload.
always_ff @(posedge i_clk)
begin
        if (take)
        begin
                we_q  <= i_req.we;
                adr_q <= i_req.adr;
                dat_q <= wdat;
                sel_q <= wsel;
        end
end

assign o_wbreq = '{pend: pend_q, we: we_q, adr: adr_q, dat: dat_q, sel: sel_q};

// Busy drops together with the response pulse.
assign o_busy = pend_q;

// ---------------------------------------------------------------------------
// Response side.
// ---------------------------------------------------------------------------

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                ack_q <= 1'b0;
                err_q <= 1'b0;
        end
        else
        begin
                ack_q <= i_done & ~i_err;
                err_q <= i_done & i_err;
        end
end

always_ff @(posedge i_clk)
begin
        if (i_done)
        begin
                rdat_q <= rdat;
        end
end

assign o_rsp = '{ack: ack_q, err: err_q, dat: rdat_q};

endmodule

`default_nettype wire

// ==== logic/bus_merger.sv ====
// Wishbone merger.
// Grants one pending port at a time, alternating when both wait,
// and runs a single-beat cycle on the external bus.

`timescale 1ns/10ps
`default_nettype none

`include "bus_settings.svh"

module bus_merger
        import bus_types_pkg::*;
        import arb_pkg::*;
(
        input  logic                          i_clk,
        input  logic                          i_arst_n,

        input  wb_req_t [`BUS_NUM_PORTS-1:0]  i_wbreq,

        output logic    [`BUS_NUM_PORTS-1:0]  o_done,
        output logic    [`BUS_NUM_PORTS-1:0]  o_err,
        output data_t                         o_rdata,

        output wb_out_t                       o_wb,
        input  wb_in_t                        i_wb
);

arb_state_e                 state_q;
arb_state_e                 state_d;

// Port currently or last granted.
port_id_t                   gnt_q;
port_id_t                   gnt_d;
port_id_t                   other;

logic [`BUS_NUM_PORTS-1:0]  pend;
logic                       cyc_end;
logic                       in_grant;
logic                       err_q;
data_t                      rdata_q;

always_comb
begin
        for (int p = 0; p < `BUS_NUM_PORTS; p++)
        begin
                pend[p] = i_wbreq[p].pend;
        end
end

assign other    = port_id_t'(~gnt_q);
assign in_grant = (state_q == GRANT);
assign cyc_end  = in_grant & (i_wb.ack | i_wb.err);

// ---------------------------------------------------------------------------
// Arbiter FSM.
// ---------------------------------------------------------------------------

always_comb
begin
        state_d = state_q;
        gnt_d   = gnt_q;

        case (state_q)
        IDLE:
        begin
                if (|pend)
                begin
                        // Other port first if it waits too.
                        gnt_d   = pend[other] ? other : gnt_q;
                        state_d = GRANT;
                end
        end

        GRANT:
        begin
                if (cyc_end)
                begin
                        state_d = DONE;
                end
        end

        // Lets the port clear pending before the next grant.
        DONE:
        begin
                state_d = IDLE;
        end

        default:
        begin
                state_d = IDLE;
        end
        endcase
end

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                state_q <= IDLE;
                gnt_q   <= port_id_t'(1);
                err_q   <= 1'b0;
        end
        else
        begin
                state_q <= state_d;
                gnt_q   <= gnt_d;
                if (cyc_end)
                begin
                        err_q <= i_wb.err;
                end
        end
end

// Read data.
always_ff @(posedge i_clk)
begin
        if (cyc_end)
        begin
                rdata_q <= i_wb.dat;
        end
end

// ---------------------------------------------------------------------------
// Outputs.
// ---------------------------------------------------------------------------

always_comb
begin
        for (int p = 0; p < `BUS_NUM_PORTS; p++)
        begin
                o_done[p] = (state_q == DONE) && (gnt_q == port_id_t'(p));
                o_err[p]  = (state_q == DONE) && (gnt_q == port_id_t'(p)) && err_q;
        end
end

assign o_rdata = rdata_q;

// Single beat only, so cti is always end-of-burst.
always_comb
begin
        o_wb.cyc = in_grant;
        o_wb.stb = in_grant;
        o_wb.we  = in_grant & i_wbreq[gnt_q].we;
        o_wb.adr = i_wbreq[gnt_q].adr;
        o_wb.dat = i_wbreq[gnt_q].dat;
        o_wb.sel = i_wbreq[gnt_q].sel;
        o_wb.cti = `BUS_CTI_EOB;
        o_wb.bte = `BUS_BTE_LINEAR;
end

endmodule

`default_nettype wire

// ==== logic/bus_top.sv ====
// External bus top.
// Code and data master ports merged onto one Wishbone bus.

`timescale 1ns/10ps
`default_nettype none

`include "bus_settings.svh"

module bus_top
        import bus_types_pkg::*;
(
        input  logic                           i_clk,
        input  logic                           i_arst_n,

        input  port_req_t [`BUS_NUM_PORTS-1:0] i_req,
        output port_rsp_t [`BUS_NUM_PORTS-1:0] o_rsp,
        output logic      [`BUS_NUM_PORTS-1:0] o_busy,

        output wb_out_t                        o_wb,
        input  wb_in_t                         i_wb
);

wb_req_t [`BUS_NUM_PORTS-1:0] wbreq;
logic    [`BUS_NUM_PORTS-1:0] done;
logic    [`BUS_NUM_PORTS-1:0] err;
data_t                        rdata;

// ---------------------------------------------------------------------------
// Ports. Only the data port may swap lanes.
// ---------------------------------------------------------------------------

for (genvar i = 0; i < `BUS_NUM_PORTS; i++)
begin : g_port
        bus_port #(
                .SWAP_LANES ((i == 1) ? `BUS_BE32_ENABLE : 1'b0)
        ) u_port (
                .i_clk    (i_clk),
                .i_arst_n (i_arst_n),
                .i_req    (i_req[i]),
                .i_done   (done[i]),
                .i_err    (err[i]),
                .i_rdata  (rdata),
                .o_wbreq  (wbreq[i]),
                .o_rsp    (o_rsp[i]),
                .o_busy   (o_busy[i])
        );
end : g_port

bus_merger u_merger (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_wbreq  (wbreq),
        .o_done   (done),
        .o_err    (err),
        .o_rdata  (rdata),
        .o_wb     (o_wb),
        .i_wb     (i_wb)
);

endmodule

`default_nettype wire

// ==== bench/bus_clk_gen.sv ====
// Testbench clock and reset.
// 20 ns clock, reset held low for the first 3 rising edges.

`timescale 1ns/10ps
`default_nettype none

module bus_clk_gen
(
        output logic o_clk,
        output logic o_arst_n
);

localparam int HALF_PERIOD = 10;
localparam int RESET_CYCLES = 3;

initial
begin
        o_clk = 1'b0;
        forever
        begin
                #HALF_PERIOD o_clk = ~o_clk;
        end
end

// Release away from the clock edge.
initial
begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_arst_n = 1'b1;
end

endmodule

`default_nettype wire

// ==== bench/bus_chk.sv ====
// Bus protocol assertions.
// Cycle type, strobe rules and request stability on the external bus.

`timescale 1ns/10ps
`default_nettype none

`include "bus_settings.svh"

module bus_chk
        import bus_types_pkg::*;
(
        input  logic                           i_clk,
        input  logic                           i_arst_n,
        input  port_req_t [`BUS_NUM_PORTS-1:0] i_req,
        input  logic      [`BUS_NUM_PORTS-1:0] i_busy,
        input  wb_out_t                        i_wbo,
        input  wb_in_t                         i_wbi
);

int fail_cnt = 0;

// Single beat, so always end-of-burst.
a_cti_eob: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wbo.cyc |-> (i_wbo.cti == `BUS_CTI_EOB) && (i_wbo.bte == `BUS_BTE_LINEAR))
else
begin
        fail_cnt++;
        $error("cycle type is not end-of-burst during a bus cycle");
end

a_stb_cyc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wbo.stb == i_wbo.cyc)
else
begin
        fail_cnt++;
        $error("stb differs from cyc");
end

// Held request fields while the slave stalls.
a_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_wbo.cyc && !i_wbi.ack && !i_wbi.err)
        |=> $stable({i_wbo.we, i_wbo.adr, i_wbo.dat, i_wbo.sel}))
else
begin
        fail_cnt++;
        $error("bus request changed while the slave was stalling");
end

for (genvar p = 0; p < `BUS_NUM_PORTS; p++)
begin : g_stb
        a_no_stb_busy: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                i_req[p].stb |-> !i_busy[p])
        else
        begin
                fail_cnt++;
                $error("port %0d strobed while busy", p);
        end
end : g_stb

endmodule

`default_nettype wire

// ==== bench/bus_monitor.sv ====
// Bus checker.
// Tracks requests per port, predicts grant order, bus fields and
// responses from the reference rules, and reports one line per test.

`timescale 1ns/10ps
`default_nettype none

`include "bus_settings.svh"

module bus_monitor
        import bus_types_pkg::*;
(
        input  logic                           i_clk,
        input  logic                           i_arst_n,
        input  port_req_t [`BUS_NUM_PORTS-1:0] i_req,
        input  port_rsp_t [`BUS_NUM_PORTS-1:0] i_rsp,
        input  logic      [`BUS_NUM_PORTS-1:0] i_busy,
        input  wb_out_t                        i_wbo,
        input  wb_in_t                         i_wbi,
        output int                             o_n_done,
        output int                             o_n_fail,
        output int                             o_n_err
);

localparam data_t WORD_MASK = 32'hA5C3_0F96;

// Port states.
localparam int ST_IDLE = 0;
localparam int ST_WAIT = 1;
localparam int ST_BUS  = 2;
localparam int ST_RSP  = 3;

int    st      [`BUS_NUM_PORTS];
int    acc_cyc [`BUS_NUM_PORTS];
int    test_id [`BUS_NUM_PORTS];
logic  bad     [`BUS_NUM_PORTS];
logic  exp_we  [`BUS_NUM_PORTS];
addr_t exp_adr [`BUS_NUM_PORTS];
data_t exp_dat [`BUS_NUM_PORTS];
sel_t  exp_sel [`BUS_NUM_PORTS];
int    act;
int    last;
int    ncyc;
int    n_tests;
logic  cyc_prev;

// ---------------------------------------------------------------------------
// Reference rules.
// ---------------------------------------------------------------------------

// Slave word is the bit-reversed address with a fixed pattern.
function automatic data_t ref_word(input addr_t a);
        data_t r;
        for (int i = 0; i < 32; i++)
        begin
                r[i] = a[31-i];
        end
        return r ^ WORD_MASK;
endfunction

function automatic data_t ref_swap(input data_t d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
endfunction

function automatic sel_t ref_sel_swap(input sel_t s);
        return {s[0], s[1], s[2], s[3]};
endfunction

// Top region of the address map answers with err.
function automatic logic ref_is_err(input addr_t a);
        return a[31:28] == 4'hF;
endfunction

// Only the data port swaps.
function automatic logic lanes(input int p);
        return (`BUS_BE32_ENABLE != 0) && (p == 1);
endfunction

task automatic check_val(input string name, input logic [31:0] got,
                         input logic [31:0] exp, input int p);
        if (got !== exp)
        begin
                $display("error: t=%0t %s got %h expected %h", $time, name, got, exp);
                o_n_err++;
                if (p >= 0)
                begin
                        bad[p] = 1'b1;
                end
        end
endtask

task automatic accept(input int p);
        n_tests++;
        test_id[p] = n_tests;
        exp_we[p]  = i_req[p].we;
        exp_adr[p] = i_req[p].adr;
        exp_dat[p] = lanes(p) ? ref_swap(i_req[p].dat) : i_req[p].dat;
        exp_sel[p] = lanes(p) ? ref_sel_swap(i_req[p].sel) : i_req[p].sel;
        acc_cyc[p] = ncyc;
        bad[p]     = 1'b0;
        st[p]      = ST_WAIT;
endtask

// A port counts for the grant once its pending level was seen in IDLE.
task automatic start_cycle();
        logic c0;
        logic c1;
        int   p;
        c0 = (st[0] == ST_WAIT) && (acc_cyc[0] <= ncyc - 2);
        c1 = (st[1] == ST_WAIT) && (acc_cyc[1] <= ncyc - 2);
        if (!c0 && !c1)
        begin
                $display("bus cycle started at %0t with no request waiting", $time);
                o_n_err++;
                act = -1;
        end
        else
        begin
                if (c0 && c1)
                begin
                        p = 1 - last;
                end
                else
                begin
                        p = c0 ? 0 : 1;
                end
                act   = p;
                last  = p;
                st[p] = ST_BUS;
                check_val("o_wb.we", i_wbo.we, exp_we[p], p);
                check_val("o_wb.adr", i_wbo.adr, exp_adr[p], p);
                check_val("o_wb.sel", i_wbo.sel, exp_sel[p], p);
                if (exp_we[p])
                begin
                        check_val("o_wb.dat", i_wbo.dat, exp_dat[p], p);
                end
        end
endtask

task automatic check_rsp(input int p);
        data_t rd;
        logic  e;
        if (st[p] != ST_RSP)
        begin
                $display("port %0d gave a response at %0t with no finished bus cycle", p, $time);
                o_n_err++;
        end
        else
        begin
                e  = ref_is_err(exp_adr[p]);
                rd = lanes(p) ? ref_swap(ref_word(exp_adr[p])) : ref_word(exp_adr[p]);
                check_val("o_rsp.err", i_rsp[p].err, e, p);
                check_val("o_rsp.ack", i_rsp[p].ack, !e, p);
                check_val("o_busy", i_busy[p], 1'b0, p);
                if (!exp_we[p] && !e)
                begin
                        check_val("o_rsp.dat", i_rsp[p].dat, rd, p);
                end
                $display("test %0d: port %0d %s at %h %s", test_id[p], p,
                         exp_we[p] ? "write" : "read", exp_adr[p], bad[p] ? "FAILED" : "ok");
                o_n_done++;
                if (bad[p])
                begin
                        o_n_fail++;
                end
                st[p] = ST_IDLE;
        end
endtask

// ---------------------------------------------------------------------------
// Sampling at the falling edge, where everything is settled.
// ---------------------------------------------------------------------------

always @(negedge i_clk)
begin
        if (!i_arst_n)
        begin
                for (int p = 0; p < `BUS_NUM_PORTS; p++)
                begin
                        st[p] = ST_IDLE;
                        check_val("o_busy", i_busy[p], 1'b0, -1);
                        check_val("o_rsp.ack", i_rsp[p].ack, 1'b0, -1);
                        check_val("o_rsp.err", i_rsp[p].err, 1'b0, -1);
                end
                check_val("o_wb.cyc", i_wbo.cyc, 1'b0, -1);
                check_val("o_wb.stb", i_wbo.stb, 1'b0, -1);
                check_val("o_wb.we", i_wbo.we, 1'b0, -1);
                act      = -1;
                last     = 1;
                ncyc     = 0;
                cyc_prev = 1'b0;
        end
        else
        begin
                ncyc++;
                for (int p = 0; p < `BUS_NUM_PORTS; p++)
                begin
                        if (st[p] == ST_IDLE && i_busy[p])
                        begin
                                $display("port %0d busy at %0t with nothing outstanding", p, $time);
                                o_n_err++;
                        end
                        // Busy from the cycle after the strobe until the response.
                        if (st[p] != ST_IDLE && acc_cyc[p] < ncyc &&
                            !(i_rsp[p].ack || i_rsp[p].err))
                        begin
                                check_val("o_busy", i_busy[p], 1'b1, p);
                        end
                        if (i_rsp[p].ack || i_rsp[p].err)
                        begin
                                check_rsp(p);
                        end
                end
                if (i_wbo.cyc)
                begin
                        if (!cyc_prev)
                        begin
                                start_cycle();
                        end
                        else if (act < 0 || st[act] != ST_BUS)
                        begin
                                $display("cyc still high at %0t after the cycle ended", $time);
                                o_n_err++;
                        end
                        if ((i_wbi.ack || i_wbi.err) && act >= 0)
                        begin
                                st[act] = ST_RSP;
                        end
                end
                cyc_prev = i_wbo.cyc;
                for (int p = 0; p < `BUS_NUM_PORTS; p++)
                begin
                        if (i_req[p].stb && !i_busy[p])
                        begin
                                accept(p);
                        end
                end
        end
end

endmodule

`default_nettype wire

// ==== bench/bus_tb.sv ====
// Testbench top for the external bus.
// Slave model with random wait states, directed and random requests
// on both ports, run limit and final verdict.

`timescale 1ns/10ps
`default_nettype none

`include "bus_settings.svh"

module bus_tb
        import bus_types_pkg::*;
();

localparam int    N_REQ      = 20;
localparam int    MAX_CYCLES = 40 * N_REQ + 100;
localparam data_t WORD_MASK  = 32'hA5C3_0F96;

logic                           clk;
logic                           arst_n;
port_req_t [`BUS_NUM_PORTS-1:0] req;
port_rsp_t [`BUS_NUM_PORTS-1:0] rsp;
logic      [`BUS_NUM_PORTS-1:0] busy;
wb_out_t                        wb_o;
wb_in_t                         wb_i;

int          n_done;
int          n_fail;
int          n_err;
int          n_sent;
int          cyc_cnt = 0;
int          wait_left;
logic        in_cycle;
integer      stim_seed = 6;
integer      wait_seed = 6;
logic [31:0] rnd;
int          port_r;
int          total;

bus_clk_gen clk_gen_i (
        .o_clk    (clk),
        .o_arst_n (arst_n)
);

bus_top dut_i (
        .i_clk    (clk),
        .i_arst_n (arst_n),
        .i_req    (req),
        .o_rsp    (rsp),
        .o_busy   (busy),
        .o_wb     (wb_o),
        .i_wb     (wb_i)
);

bus_monitor mon_i (
        .i_clk    (clk),
        .i_arst_n (arst_n),
        .i_req    (req),
        .i_rsp    (rsp),
        .i_busy   (busy),
        .i_wbo    (wb_o),
        .i_wbi    (wb_i),
        .o_n_done (n_done),
        .o_n_fail (n_fail),
        .o_n_err  (n_err)
);

bind bus_top bus_chk chk_i (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_req    (i_req),
        .i_busy   (o_busy),
        .i_wbo    (o_wb),
        .i_wbi    (i_wb)
);

// ---------------------------------------------------------------------------
// Slave model.
// ---------------------------------------------------------------------------

function automatic data_t slave_word(input addr_t a);
        data_t r;
        for (int i = 0; i < 32; i++)
        begin
                r[i] = a[31-i];
        end
        return r ^ WORD_MASK;
endfunction

function automatic logic in_err_region(input addr_t a);
        return a[31:28] == 4'hF;
endfunction

initial
begin
        wb_i      = '0;
        wait_left = 0;
        in_cycle  = 1'b0;
        forever
        begin
                @(posedge clk);
                #1;
                if (wb_i.ack || wb_i.err)
                begin
                        wb_i = '0;
                end
                else if (wb_o.cyc)
                begin
                        if (!in_cycle)
                        begin
                                in_cycle  = 1'b1;
                                wait_left = $unsigned($random(wait_seed)) % 4;
                        end
                        if (wait_left == 0)
                        begin
                                in_cycle = 1'b0;
                                wb_i.err = in_err_region(wb_o.adr);
                                wb_i.ack = !in_err_region(wb_o.adr);
                                wb_i.dat = wb_o.we ? '0 : slave_word(wb_o.adr);
                        end
                        else
                        begin
                                wait_left--;
                        end
                end
        end
end

// ---------------------------------------------------------------------------
// Stimulus is driven 1 ns after a rising edge.
// ---------------------------------------------------------------------------

task automatic send(input int p, input logic we, input addr_t adr,
                    input data_t dat, input sel_t sel);
        while (busy[p])
        begin
                @(posedge clk);
                #1;
        end
        req[p] = '{stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
        n_sent++;
        @(posedge clk);
        #1;
        req[p].stb = 1'b0;
endtask

// Two reads strobed in the same cycle.
task automatic send_pair(input addr_t adr0, input addr_t adr1);
        while (busy[0] || busy[1])
        begin
                @(posedge clk);
                #1;
        end
        req[0] = '{stb: 1'b1, we: 1'b0, adr: adr0, dat: '0, sel: 4'hF};
        req[1] = '{stb: 1'b1, we: 1'b0, adr: adr1, dat: '0, sel: 4'hF};
        n_sent += 2;
        @(posedge clk);
        #1;
        req[0].stb = 1'b0;
        req[1].stb = 1'b0;
endtask

task automatic wait_all();
        while (n_done < n_sent)
        begin
                @(posedge clk);
                #1;
        end
endtask

initial
begin
        req    = '0;
        n_sent = 0;
        @(posedge arst_n);
        @(posedge clk);
        #1;
        send(0, 1'b0, 32'h0000_1000, '0, 4'hF);
        wait_all();
        send(1, 1'b1, 32'h0000_2004, 32'h1122_3344, 4'b0011);
        wait_all();
        send(1, 1'b0, 32'h0000_3008, '0, 4'hF);
        wait_all();
        repeat (3)
        begin
                send_pair($random(stim_seed) & 32'h0FFF_FFFC,
                          $random(stim_seed) & 32'h0FFF_FFFC);
        end
        wait_all();
        send(0, 1'b0, 32'hF000_0020, '0, 4'hF);
        wait_all();
        // Error on the data port while the code port reads.
        // The code port was granted last, so the data port goes first.
        send_pair(32'h0000_4000, 32'hF000_0010);
        wait_all();
        repeat (8)
        begin
                rnd    = $random(stim_seed);
                port_r = rnd[0];
                send(port_r, rnd[1], $random(stim_seed) & 32'h0FFF_FFFC, $random(stim_seed),
                     rnd[1] ? ((rnd[7:4] == 4'h0) ? 4'h1 : rnd[7:4]) : 4'hF);
        end
        wait_all();
        repeat (5) @(posedge clk);
        #1;
        total = n_fail + n_err + dut_i.chk_i.fail_cnt;
        $display("%0d of %0d tests done, %0d failed, %0d errors, %0d assertion failures",
                 n_done, N_REQ, n_fail, n_err, dut_i.chk_i.fail_cnt);
        if (total == 0 && n_done == N_REQ && n_sent == N_REQ)
        begin
                $display("TEST RESULT: PASS");
        end
        else
        begin
                $display("TEST RESULT: FAIL");
        end
        $finish;
end

// Run limit.
always @(posedge clk)
begin
        cyc_cnt++;
        if (cyc_cnt > MAX_CYCLES)
        begin
                $display("timeout: %0d of %0d responses after %0d cycles",
                         n_done, N_REQ, MAX_CYCLES);
                $display("TEST RESULT: FAIL");
                $finish;
        end
end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
logic/bus_types_pkg.sv
logic/arb_pkg.sv
logic/bus_port.sv
logic/bus_merger.sv
logic/bus_top.sv
bench/bus_clk_gen.sv
bench/bus_chk.sv
bench/bus_monitor.sv
bench/bus_tb.sv
